// ==== verilog/mul_types_pkg.sv ====
// Arithmetic definitions shared by the multiply unit: word widths, opcodes and tag width
package mul_types_pkg;

  // Operand and result word
  localparam int WORD_WIDTH = 32;

  // Digit width used for the partial products
  localparam int NIBBLE_WIDTH = 4;

  // Nibbles per operand, eight for a 32-bit word
  localparam int NIBBLE_COUNT = WORD_WIDTH / NIBBLE_WIDTH;

  // Full unsigned product keeps both halves
  localparam int PRODUCT_WIDTH = 2 * WORD_WIDTH;

  // Destination register tag, one of 32 architectural registers
  localparam int TAG_WIDTH = 5;

  // Multiply opcodes
  // Encoding follows the low two bits of the RV32M funct3 field
  typedef enum logic [1:0] {
    // Low word, signed x signed
    OP_MUL    = 2'b00,
    // High word, signed x signed
    OP_MULH   = 2'b01,
    // High word, signed rs1 x unsigned rs2
    OP_MULHSU = 2'b10,
    // High word, unsigned x unsigned
    OP_MULHU  = 2'b11
  } mul_op_e;

  // Only MULHU treats rs1 as unsigned
  //   MUL, MULH   : both operands signed
  //   MULHSU      : rs1 signed, rs2 unsigned
  //   MULHU       : both operands unsigned
  // Only MUL returns the low word, the rest return the high word

endpackage

// ==== verilog/mul_pipe_pkg.sv ====
// Microarchitecture sizing of the multiply unit: tree depth and result buffer
package mul_pipe_pkg;

  import mul_types_pkg::*;

  // Register levels in the nibble tree, also the multiplier latency
  localparam int TREE_STAGES = 4;

  // Shifted nibble products entering the first tree level
  localparam int PP_COUNT = NIBBLE_COUNT * NIBBLE_COUNT;

  // Result FIFO entries
  localparam int BUF_DEPTH = 8;

  // FIFO pointer width, wraps naturally at BUF_DEPTH
  localparam int BUF_PTR_WIDTH = 3;

  // Occupancy plus in-flight counter
  // Needs to hold BUF_DEPTH and one pending start on top of it
  localparam int CREDIT_WIDTH = 4;

endpackage

// ==== verilog/mul_issue_stage.sv ====
// Multiply issue stage: registers requests, forms operand magnitudes and tracks product sign
`timescale 1ns/10ps

module mul_issue_stage (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 req,
  input  mul_types_pkg::mul_op_e               op,
  input  logic [mul_types_pkg::WORD_WIDTH-1:0] rs1,
  input  logic [mul_types_pkg::WORD_WIDTH-1:0] rs2,
  input  logic [mul_types_pkg::TAG_WIDTH-1:0]  rd_tag,
  input  logic                                 stall,
  output logic                                 start,
  output logic [mul_types_pkg::WORD_WIDTH-1:0] mag_a,
  output logic [mul_types_pkg::WORD_WIDTH-1:0] mag_b,
  output mul_types_pkg::mul_op_e               out_op,
  output logic [mul_types_pkg::TAG_WIDTH-1:0]  out_tag,
  output logic                                 out_negate
);

  import mul_types_pkg::*;
  import mul_pipe_pkg::*;

  logic                  accept;
  logic                  a_negative;
  logic                  b_negative;

  // Sideband held beside start
  mul_op_e               issue_op;
  logic [TAG_WIDTH-1:0]  issue_tag;
  logic                  issue_negate;

  // Sideband delay line, one entry per tree stage
  mul_op_e               op_line     [TREE_STAGES];
  logic [TAG_WIDTH-1:0]  tag_line    [TREE_STAGES];
  logic                  negate_line [TREE_STAGES];

  // Requests seen during stall are dropped, the decoder holds them
  assign accept = req & ~stall;

  // rs1 is signed for all but MULHU, rs2 only for MUL and MULH
  assign a_negative = (op != OP_MULHU) & rs1[WORD_WIDTH-1];
  assign b_negative = ((op == OP_MUL) | (op == OP_MULH)) & rs2[WORD_WIDTH-1];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      start <= 1'b0;
    else
      start <= accept;
  end

  // Most negative input maps to magnitude 2^31, still exact as unsigned
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      mag_a        <= a_negative ? (~rs1 + 1'b1) : rs1;
      mag_b        <= b_negative ? (~rs2 + 1'b1) : rs2;
      issue_op     <= op;
      issue_tag    <= rd_tag;
      issue_negate <= a_negative ^ b_negative;
    end
  end

  // Shifts every cycle so the tail lines up with done
  always_ff @(posedge clk)
  begin
    op_line[0]     <= issue_op;
    tag_line[0]    <= issue_tag;
    negate_line[0] <= issue_negate;
    for (int k = 1; k < TREE_STAGES; k++)
    begin
      op_line[k]     <= op_line[k-1];
      tag_line[k]    <= tag_line[k-1];
      negate_line[k] <= negate_line[k-1];
    end
  end

  assign out_op     = op_line[TREE_STAGES-1];
  assign out_tag    = tag_line[TREE_STAGES-1];
  assign out_negate = negate_line[TREE_STAGES-1];

endmodule

// ==== verilog/nibble_tree_multiplier.sv ====
// Pipelined unsigned multiplier built from nibble partial products and a pairwise adder tree
`timescale 1ns/10ps

module nibble_tree_multiplier (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  logic                                    start,
  input  logic [mul_types_pkg::WORD_WIDTH-1:0]    a,
  input  logic [mul_types_pkg::WORD_WIDTH-1:0]    b,
  output logic                                    done,
  output logic [mul_types_pkg::PRODUCT_WIDTH-1:0] product
);

  import mul_types_pkg::*;
  import mul_pipe_pkg::*;

  // Shifted nibble products before the first register level
  logic [PRODUCT_WIDTH-1:0] pp_comb [PP_COUNT];

  // Registered tree levels, 64 then 32, 16 and 8 terms
  logic [PRODUCT_WIDTH-1:0] level_1 [PP_COUNT];
  logic [PRODUCT_WIDTH-1:0] level_2 [PP_COUNT/2];
  logic [PRODUCT_WIDTH-1:0] level_3 [PP_COUNT/4];
  logic [PRODUCT_WIDTH-1:0] level_4 [PP_COUNT/8];

  // Start travels beside the data, one bit per level
  logic [TREE_STAGES-1:0]   stage_valid;

  // Nibble i of a times nibble j of b, weighted by 16^(i+j)
  always_comb
  begin
    for (int i = 0; i < NIBBLE_COUNT; i++)
    begin
      for (int j = 0; j < NIBBLE_COUNT; j++)
      begin
        pp_comb[i*NIBBLE_COUNT + j] =
          (PRODUCT_WIDTH'(a[i*NIBBLE_WIDTH +: NIBBLE_WIDTH]) *
           PRODUCT_WIDTH'(b[j*NIBBLE_WIDTH +: NIBBLE_WIDTH])) << ((i + j) * NIBBLE_WIDTH);
      end
    end
  end

  // First level just captures the partial products
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < PP_COUNT; k++)
    begin
      level_1[k] <= pp_comb[k];
    end
  end

  // Each following level adds neighbouring pairs
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < PP_COUNT/2; k++)
    begin
      level_2[k] <= level_1[2*k] + level_1[2*k + 1];
    end
    for (int k = 0; k < PP_COUNT/4; k++)
    begin
      level_3[k] <= level_2[2*k] + level_2[2*k + 1];
    end
    for (int k = 0; k < PP_COUNT/8; k++)
    begin
      level_4[k] <= level_3[2*k] + level_3[2*k + 1];
    end
  end

  // Last eight terms summed after the final register
  // No carry leaves bit 63 since a 32x32 product fits in 64 bits
  always_comb
  begin
    product = '0;
    for (int k = 0; k < PP_COUNT/8; k++)
    begin
      product = product + level_4[k];
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      stage_valid <= '0;
    else
      stage_valid <= {stage_valid[TREE_STAGES-2:0], start};
  end

  // Goes high together with the product of the matching start
  assign done = stage_valid[TREE_STAGES-1];

endmodule

// ==== verilog/mul_result_buffer.sv ====
// Result FIFO for finished products with credit-based stall covering in-flight operations
`timescale 1ns/10ps

module mul_result_buffer (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  logic                                    start,
  input  logic                                    done,
  input  logic [mul_types_pkg::PRODUCT_WIDTH-1:0] product,
  input  mul_types_pkg::mul_op_e                  op,
  input  logic [mul_types_pkg::TAG_WIDTH-1:0]     tag,
  input  logic                                    negate,
  input  logic                                    pop,
  output logic                                    head_valid,
  output logic [mul_types_pkg::PRODUCT_WIDTH-1:0] head_product,
  output mul_types_pkg::mul_op_e                  head_op,
  output logic [mul_types_pkg::TAG_WIDTH-1:0]     head_tag,
  output logic                                    head_negate,
  output logic                                    stall
);

  import mul_types_pkg::*;
  import mul_pipe_pkg::*;

  logic [PRODUCT_WIDTH-1:0] product_mem [BUF_DEPTH];
  mul_op_e                  op_mem      [BUF_DEPTH];
  logic [TAG_WIDTH-1:0]     tag_mem     [BUF_DEPTH];
  logic                     negate_mem  [BUF_DEPTH];

  logic [BUF_PTR_WIDTH-1:0] wr_ptr;
  logic [BUF_PTR_WIDTH-1:0] rd_ptr;

  // Entries currently stored
  logic [CREDIT_WIDTH-1:0]  occupancy;
  // Stored entries plus operations started but not yet done
  logic [CREDIT_WIDTH-1:0]  credit;
  // Credit including a start arriving this cycle
  logic [CREDIT_WIDTH-1:0]  credit_demand;

  // Payload storage written on done
  always_ff @(posedge clk)
  begin
    if (done)
    begin
      product_mem[wr_ptr] <= product;
      op_mem[wr_ptr]      <= op;
      tag_mem[wr_ptr]     <= tag;
      negate_mem[wr_ptr]  <= negate;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end
    else
    begin
      if (done)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({done, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  // Credit is reserved at start, so every done has a free slot
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      credit <= '0;
    else
      case ({start, pop})
        2'b10:   credit <= credit + 1'b1;
        2'b01:   credit <= credit - 1'b1;
        default: credit <= credit;
      endcase
  end

  // Start lags acceptance by a cycle, so count it before it lands in credit
  assign credit_demand = credit + CREDIT_WIDTH'(start);
  assign stall         = (credit_demand >= CREDIT_WIDTH'(BUF_DEPTH));

  // Head entry shown as a level
  assign head_valid   = (occupancy != '0);
  assign head_product = product_mem[rd_ptr];
  assign head_op      = op_mem[rd_ptr];
  assign head_tag     = tag_mem[rd_ptr];
  assign head_negate  = negate_mem[rd_ptr];

endmodule

// ==== verilog/mul_writeback.sv ====
// Multiply writeback: applies product sign, selects the word per opcode and drives the result port
`timescale 1ns/10ps

module mul_writeback (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  logic                                    head_valid,
  input  logic [mul_types_pkg::PRODUCT_WIDTH-1:0] head_product,
  input  mul_types_pkg::mul_op_e                  head_op,
  input  logic [mul_types_pkg::TAG_WIDTH-1:0]     head_tag,
  input  logic                                    head_negate,
  input  logic                                    wb_grant,
  output logic                                    pop,
  output logic                                    wb_valid,
  output logic [mul_types_pkg::WORD_WIDTH-1:0]    wb_data,
  output logic [mul_types_pkg::TAG_WIDTH-1:0]     wb_tag,
  output logic                                    wb_overflow
);

  import mul_types_pkg::*;

  logic [PRODUCT_WIDTH-1:0] signed_product;
  logic [WORD_WIDTH-1:0]    low_word;
  logic [WORD_WIDTH-1:0]    high_word;
  logic [WORD_WIDTH-1:0]    selected_word;
  logic                     overflow_next;

  // Head leaves the buffer whenever the shared port is ours
  assign pop = head_valid & wb_grant;

  // Two's complement of the magnitude when the operand signs differ
  assign signed_product = head_negate ? (~head_product + 1'b1) : head_product;

  assign low_word  = signed_product[WORD_WIDTH-1:0];
  assign high_word = signed_product[PRODUCT_WIDTH-1:WORD_WIDTH];

  // MUL keeps the low word, MULH/MULHSU/MULHU the high word
  assign selected_word = (head_op == OP_MUL) ? low_word : high_word;

  // Product fits in 32 bits only if the high word is a sign extension of the low word
  always_comb
  begin
    if (head_op == OP_MUL)
      overflow_next = (high_word != {WORD_WIDTH{low_word[WORD_WIDTH-1]}});
    else
      overflow_next = 1'b0;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      wb_valid <= 1'b0;
    else
      wb_valid <= pop;
  end

  // Result payload, meaningful only while wb_valid is high
  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      wb_data     <= selected_word;
      wb_tag      <= head_tag;
      wb_overflow <= overflow_next;
    end
  end

endmodule

// ==== verilog/mul_unit_top.sv ====
// Integer multiply unit: issue stage, nibble tree, result FIFO and writeback port
`timescale 1ns/10ps

module mul_unit_top (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 req,
  input  mul_types_pkg::mul_op_e               op,
  input  logic [mul_types_pkg::WORD_WIDTH-1:0] rs1,
  input  logic [mul_types_pkg::WORD_WIDTH-1:0] rs2,
  input  logic [mul_types_pkg::TAG_WIDTH-1:0]  rd_tag,
  input  logic                                 wb_grant,
  output logic                                 stall,
  output logic                                 wb_valid,
  output logic [mul_types_pkg::WORD_WIDTH-1:0] wb_data,
  output logic [mul_types_pkg::TAG_WIDTH-1:0]  wb_tag,
  output logic                                 wb_overflow
);

  import mul_types_pkg::*;

  // Issue to multiplier
  logic                     start;
  logic [WORD_WIDTH-1:0]    mag_a;
  logic [WORD_WIDTH-1:0]    mag_b;

  // Multiplier and sideband into the buffer
  logic                     done;
  logic [PRODUCT_WIDTH-1:0] product;
  mul_op_e                  side_op;
  logic [TAG_WIDTH-1:0]     side_tag;
  logic                     side_negate;

  // Buffer head to writeback
  logic                     head_valid;
  logic [PRODUCT_WIDTH-1:0] head_product;
  mul_op_e                  head_op;
  logic [TAG_WIDTH-1:0]     head_tag;
  logic                     head_negate;
  logic                     pop;

  mul_issue_stage issue_stage_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .op         (op),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd_tag     (rd_tag),
    .stall      (stall),
    .start      (start),
    .mag_a      (mag_a),
    .mag_b      (mag_b),
    .out_op     (side_op),
    .out_tag    (side_tag),
    .out_negate (side_negate)
  );

  nibble_tree_multiplier multiplier_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (start),
    .a       (mag_a),
    .b       (mag_b),
    .done    (done),
    .product (product)
  );

  mul_result_buffer result_buffer_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .start        (start),
    .done         (done),
    .product      (product),
    .op           (side_op),
    .tag          (side_tag),
    .negate       (side_negate),
    .pop          (pop),
    .head_valid   (head_valid),
    .head_product (head_product),
    .head_op      (head_op),
    .head_tag     (head_tag),
    .head_negate  (head_negate),
    .stall        (stall)
  );

  mul_writeback writeback_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .head_valid   (head_valid),
    .head_product (head_product),
    .head_op      (head_op),
    .head_tag     (head_tag),
    .head_negate  (head_negate),
    .wb_grant     (wb_grant),
    .pop          (pop),
    .wb_valid     (wb_valid),
    .wb_data      (wb_data),
    .wb_tag       (wb_tag),
    .wb_overflow  (wb_overflow)
  );

endmodule

// ==== verification/mul_unit_checker.sv ====
// Concurrent assertions on the multiply unit's writeback port, stall and result FIFO
`timescale 1ns/10ps

module mul_unit_checker (
  input logic                                  clk,
  input logic                                  arst_n,
  input logic                                  req,
  input logic                                  stall,
  input logic                                  wb_grant,
  input logic                                  wb_valid,
  input logic [mul_pipe_pkg::CREDIT_WIDTH-1:0] occupancy
);

  import mul_pipe_pkg::*;

  // Each result was popped while the port was granted
  wb_valid_needs_grant: assert property (
    @(posedge clk) disable iff (!arst_n) wb_valid |-> $past(wb_grant)
  ) else $error("wb_valid high without wb_grant in the previous cycle");

  // Credit starts at zero when reset is released
  stall_low_after_reset: assert property (
    @(posedge clk) $rose(arst_n) |-> !stall
  ) else $error("stall high right after reset");

  // No request gets in while every FIFO entry is taken
  no_accept_when_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    (req && !stall) |-> (occupancy < CREDIT_WIDTH'(BUF_DEPTH))
  ) else $error("request accepted with the result FIFO full");

  fifo_never_overfills: assert property (
    @(posedge clk) disable iff (!arst_n) occupancy <= CREDIT_WIDTH'(BUF_DEPTH)
  ) else $error("result FIFO occupancy above its depth");

endmodule

bind mul_unit_top mul_unit_checker mul_unit_checker_inst (
  .clk       (clk),
  .arst_n    (arst_n),
  .req       (req),
  .stall     (stall),
  .wb_grant  (wb_grant),
  .wb_valid  (wb_valid),
  .occupancy (result_buffer_inst.occupancy)
);

// ==== verification/mul_unit_tb.sv ====
// Multiply unit testbench covering corners, latency, streaming, back-pressure and random grant
`timescale 1ns/10ps

module mul_unit_tb;

  import mul_types_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int CORNER_ROWS = 18;
  localparam int STREAM_ROWS = 32;
  // Same as the result FIFO depth
  localparam int FILL_ROWS   = 8;
  localparam int RANDOM_ROWS = 48;
  localparam int TOTAL_ROWS  = CORNER_ROWS + 1 + STREAM_ROWS + FILL_ROWS + RANDOM_ROWS;
  localparam int LATENCY     = 6;

  // One stimulus row with its precomputed result
  typedef struct packed {
    mul_op_e               op;
    logic [WORD_WIDTH-1:0] a;
    logic [WORD_WIDTH-1:0] b;
    logic [7:0]            grant;
    logic [WORD_WIDTH-1:0] data;
    logic                  ovf;
  } row_t;

  // Corners for every opcode with a grant pattern that rotates one bit per cycle
  row_t corner_table [CORNER_ROWS] = '{
    '{OP_MUL,    32'h00000000, 32'h12345678, 8'hff, 32'h00000000, 1'b0},
    '{OP_MUL,    32'h00000001, 32'hffffffff, 8'hff, 32'hffffffff, 1'b0},
    '{OP_MUL,    32'hffffffff, 32'hffffffff, 8'hff, 32'h00000001, 1'b0},
    '{OP_MUL,    32'h80000000, 32'hffffffff, 8'hff, 32'h80000000, 1'b1},
    '{OP_MUL,    32'h80000000, 32'h80000000, 8'h5a, 32'h00000000, 1'b1},
    '{OP_MUL,    32'h00010000, 32'h00010000, 8'h5a, 32'h00000000, 1'b1},
    '{OP_MUL,    32'h7fffffff, 32'h00000002, 8'h5a, 32'hfffffffe, 1'b1},
    '{OP_MUL,    32'hfffffffe, 32'h00000003, 8'hff, 32'hfffffffa, 1'b0},
    '{OP_MULH,   32'hffffffff, 32'hffffffff, 8'hff, 32'h00000000, 1'b0},
    '{OP_MULH,   32'h80000000, 32'h80000000, 8'hff, 32'h40000000, 1'b0},
    '{OP_MULH,   32'h80000000, 32'h7fffffff, 8'h33, 32'hc0000000, 1'b0},
    '{OP_MULH,   32'hfffffffe, 32'h00000003, 8'h33, 32'hffffffff, 1'b0},
    '{OP_MULHSU, 32'hffffffff, 32'hffffffff, 8'h33, 32'hffffffff, 1'b0},
    '{OP_MULHSU, 32'h80000000, 32'hffffffff, 8'hff, 32'h80000000, 1'b0},
    '{OP_MULHSU, 32'h00000002, 32'h80000000, 8'hff, 32'h00000001, 1'b0},
    '{OP_MULHU,  32'hffffffff, 32'hffffffff, 8'hff, 32'hfffffffe, 1'b0},
    '{OP_MULHU,  32'h80000000, 32'h00000002, 8'hff, 32'h00000001, 1'b0},
    '{OP_MULHU,  32'h00000000, 32'hffffffff, 8'hff, 32'h00000000, 1'b0}
  };

  logic                  clk;
  logic                  arst_n;
  logic                  req;
  mul_op_e               op;
  logic [WORD_WIDTH-1:0] rs1;
  logic [WORD_WIDTH-1:0] rs2;
  logic [TAG_WIDTH-1:0]  rd_tag;
  logic                  wb_grant;
  logic                  stall;
  logic                  wb_valid;
  logic [WORD_WIDTH-1:0] wb_data;
  logic [TAG_WIDTH-1:0]  wb_tag;
  logic                  wb_overflow;

  // Expected results in acceptance order
  logic [WORD_WIDTH-1:0] exp_data_q [$];
  logic [TAG_WIDTH-1:0]  exp_tag_q  [$];
  logic                  exp_ovf_q  [$];

  logic [31:0]           lfsr_state;
  logic [7:0]            grant_pattern;
  logic [2:0]            grant_phase;
  logic                  grant_random;
  logic [TAG_WIDTH-1:0]  next_tag;
  int                    cycle_count;
  int                    accept_cycle;
  int                    valid_cycle;
  int                    result_count;
  int                    drop_count;
  int                    error_count;
  int                    check_count;
  int                    test_number;
  int                    tests_failed;
  int                    errors_before;
  int                    results_before;
  int                    drops_before;
  int                    stream_start;

  mul_unit_top mul_unit_top_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (req),
    .op          (op),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd_tag      (rd_tag),
    .wb_grant    (wb_grant),
    .stall       (stall),
    .wb_valid    (wb_valid),
    .wb_data     (wb_data),
    .wb_tag      (wb_tag),
    .wb_overflow (wb_overflow)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  always @(posedge clk)
    cycle_count <= cycle_count + 1;

  // Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] value;
    value = '0;
    for (int k = 0; k < nbits; k++)
    begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return value;
  endfunction

  // Reference model sign-extends per opcode and multiplies at full width
  // Returns the overflow flag above the result word
  function automatic logic [WORD_WIDTH:0] ref_result(input mul_op_e o,
                                                     input logic [WORD_WIDTH-1:0] a,
                                                     input logic [WORD_WIDTH-1:0] b);
    logic [PRODUCT_WIDTH-1:0] wide_a;
    logic [PRODUCT_WIDTH-1:0] wide_b;
    logic [PRODUCT_WIDTH-1:0] full;
    logic                     ovf;
    wide_a = (o == OP_MULHU) ? {{WORD_WIDTH{1'b0}}, a} : {{WORD_WIDTH{a[WORD_WIDTH-1]}}, a};
    wide_b = (o == OP_MUL || o == OP_MULH) ? {{WORD_WIDTH{b[WORD_WIDTH-1]}}, b}
                                           : {{WORD_WIDTH{1'b0}}, b};
    full   = wide_a * wide_b;
    // MUL overflows when the signed product lies outside the 32-bit signed range
    ovf    = (o == OP_MUL) &&
             (($signed(full) > 64'sh000000007fffffff) ||
              ($signed(full) < -64'sh0000000080000000));
    if (o == OP_MUL)
      return {ovf, full[WORD_WIDTH-1:0]};
    else
      return {1'b0, full[PRODUCT_WIDTH-1:WORD_WIDTH]};
  endfunction

  task automatic check_word(input string name, input logic [WORD_WIDTH-1:0] got,
                            input logic [WORD_WIDTH-1:0] want);
    check_count++;
    if (got !== want)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, want);
      error_count++;
    end
  endtask

  task automatic check_tag(input string name, input logic [TAG_WIDTH-1:0] got,
                           input logic [TAG_WIDTH-1:0] want);
    check_count++;
    if (got !== want)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, want);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    check_count++;
    if (got !== want)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, want);
      error_count++;
    end
  endtask

  // Advance to just after the next rising edge and drive the grant for that cycle
  task automatic next_cycle();
    logic [31:0] bits;
    @(posedge clk);
    #1;
    if (grant_random)
    begin
      bits     = lfsr_take(1);
      wb_grant = bits[0];
    end
    else
    begin
      wb_grant    = grant_pattern[grant_phase];
      grant_phase = grant_phase + 1'b1;
    end
  endtask

  // Holds the request until the unit takes it and reads stall mid-cycle
  task automatic issue(input mul_op_e o, input logic [WORD_WIDTH-1:0] a,
                       input logic [WORD_WIDTH-1:0] b, input logic [WORD_WIDTH-1:0] want_data,
                       input logic want_ovf);
    logic taken;
    taken = 1'b0;
    while (!taken)
    begin
      req    = 1'b1;
      op     = o;
      rs1    = a;
      rs2    = b;
      rd_tag = next_tag;
      @(negedge clk);
      taken = !stall;
      if (taken)
      begin
        exp_data_q.push_back(want_data);
        exp_tag_q.push_back(next_tag);
        exp_ovf_q.push_back(want_ovf);
        accept_cycle = cycle_count + 1;
        next_tag     = next_tag + 1'b1;
      end
      else
        drop_count++;
      next_cycle();
    end
    req = 1'b0;
  endtask

  // Arithmetic shift keeps negative operands while bringing products near 32 bits
  task automatic issue_random();
    logic [31:0]           code;
    logic [31:0]           shift;
    logic [WORD_WIDTH-1:0] a;
    logic [WORD_WIDTH-1:0] b;
    logic [WORD_WIDTH:0]   model;
    mul_op_e               o;
    code  = lfsr_take(2);
    o     = mul_op_e'(code[1:0]);
    a     = lfsr_take(WORD_WIDTH);
    shift = lfsr_take(4);
    a     = $signed(a) >>> shift[3:0];
    b     = lfsr_take(WORD_WIDTH);
    shift = lfsr_take(4);
    b     = $signed(b) >>> shift[3:0];
    model = ref_result(o, a, b);
    issue(o, a, b, model[WORD_WIDTH-1:0], model[WORD_WIDTH]);
  endtask

  // Waits for every pending result and then a few idle cycles to catch extras
  task automatic drain();
    grant_pattern = 8'hff;
    while (exp_data_q.size() != 0)
      next_cycle();
    repeat (4) next_cycle();
  endtask

  task automatic end_test(input string name);
    test_number++;
    if (error_count == errors_before)
      $display("test %0d %-34s ok", test_number, name);
    else
    begin
      $display("test %0d %-34s failed, %0d errors", test_number, name,
               error_count - errors_before);
      tests_failed++;
    end
    errors_before = error_count;
  endtask

  // Result monitor samples the port at the falling edge
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (arst_n && wb_valid)
      begin
        result_count++;
        valid_cycle = cycle_count;
        if (exp_data_q.size() == 0)
        begin
          $display("wb_valid with no result pending, tag %h data %h", wb_tag, wb_data);
          error_count++;
        end
        else
        begin
          check_word("wb_data", wb_data, exp_data_q.pop_front());
          check_tag("wb_tag", wb_tag, exp_tag_q.pop_front());
          check_flag("wb_overflow", wb_overflow, exp_ovf_q.pop_front());
        end
      end
    end
  end

  initial
  begin
    repeat (TOTAL_ROWS * 20 + 200) @(posedge clk);
    $display("watchdog expired with %0d results still pending", exp_data_q.size());
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    arst_n        = 1'b0;
    req           = 1'b0;
    op            = OP_MUL;
    rs1           = '0;
    rs2           = '0;
    rd_tag        = '0;
    wb_grant      = 1'b0;
    lfsr_state    = 32'hfd91;
    grant_pattern = 8'hff;
    grant_phase   = '0;
    grant_random  = 1'b0;
    next_tag      = '0;
    cycle_count   = 0;
    result_count  = 0;
    drop_count    = 0;
    error_count   = 0;
    check_count   = 0;
    test_number   = 0;
    tests_failed  = 0;
    errors_before = 0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    next_cycle();

    for (int r = 0; r < CORNER_ROWS; r++)
    begin
      grant_pattern = corner_table[r].grant;
      issue(corner_table[r].op, corner_table[r].a, corner_table[r].b,
            corner_table[r].data, corner_table[r].ovf);
    end
    drain();
    end_test("corner table, all opcodes");

    // Empty buffer and grant high give the fixed pipeline latency
    issue(OP_MULHU, 32'h00010000, 32'h00030000, 32'h00000003, 1'b0);
    drain();
    if (valid_cycle - accept_cycle != LATENCY)
    begin
      $display("isolated request took %0d cycles, expected %0d",
               valid_cycle - accept_cycle, LATENCY);
      error_count++;
    end
    end_test("isolated request latency");

    drops_before   = drop_count;
    results_before = result_count;
    for (int r = 0; r < STREAM_ROWS; r++)
    begin
      issue_random();
      if (r == 0)
        stream_start = accept_cycle;
    end
    drain();
    if (drop_count != drops_before || result_count - results_before != STREAM_ROWS ||
        valid_cycle - stream_start != STREAM_ROWS - 1 + LATENCY)
    begin
      $display("back-to-back stream did not give one result per cycle");
      error_count++;
    end
    end_test("back-to-back random stream");

    // Grant low fills the buffer until the credit limit stalls issue
    grant_pattern  = 8'h00;
    drops_before   = drop_count;
    results_before = result_count;
    for (int r = 0; r < FILL_ROWS; r++)
      issue_random();
    if (drop_count != drops_before || !stall)
    begin
      $display("stall did not rise exactly after %0d accepted requests", FILL_ROWS);
      error_count++;
    end
    req    = 1'b1;
    op     = OP_MUL;
    rs1    = 32'h00000005;
    rs2    = 32'h00000007;
    rd_tag = next_tag;
    repeat (4)
    begin
      @(negedge clk);
      if (!stall)
      begin
        $display("stall fell while grant was held low");
        error_count++;
      end
      next_cycle();
    end
    req = 1'b0;
    drain();
    if (result_count - results_before != FILL_ROWS)
    begin
      $display("drain gave %0d results, expected %0d", result_count - results_before, FILL_ROWS);
      error_count++;
    end
    end_test("back-pressure with grant low");

    grant_random   = 1'b1;
    results_before = result_count;
    for (int r = 0; r < RANDOM_ROWS; r++)
    begin
      issue_random();
      if (lfsr_take(1) == 32'd1)
        next_cycle();
    end
    while (exp_data_q.size() != 0)
      next_cycle();
    grant_random = 1'b0;
    drain();
    if (result_count - results_before != RANDOM_ROWS)
    begin
      $display("random grant run gave %0d results, expected %0d",
               result_count - results_before, RANDOM_ROWS);
      error_count++;
    end
    end_test("random grant and requests");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_number, tests_failed, check_count, error_count);
    if (error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/mul_types_pkg.sv
verilog/mul_pipe_pkg.sv
verilog/mul_issue_stage.sv
verilog/nibble_tree_multiplier.sv
verilog/mul_result_buffer.sv
verilog/mul_writeback.sv
verilog/mul_unit_top.sv
verification/mul_unit_checker.sv
verification/mul_unit_tb.sv
